// File: arb_pkg.sv
////////////////////////////////////////
// arbiter shared definitions
////////////////////////////////////////

`default_nettype none

package arb_pkg;

  ////////////////////////////////////////
  // default sizes

  // number of requesters, deliberately not a power of two
  localparam int unsigned NumInDefault     = 5;

  // payload width of one request
  localparam int unsigned DataWidthDefault = 16;

  // width of a requester index and of the round-robin priority
  localparam int unsigned IdxWidthDefault  = $clog2(NumInDefault);

  ////////////////////////////////////////
  // types

  // payload carried by one request
  typedef logic [DataWidthDefault-1:0] payload_t;

  // requester index, also used for the round-robin priority
  typedef logic [IdxWidthDefault-1:0]  idx_t;

endpackage : arb_pkg

`default_nettype wire

// File: arb_win_if.sv
////////////////////////////////////////
// arbiter winner channel
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

// carries the winning request from the arbitration tree to the output stage
// a transfer happens in every cycle with req and gnt both high
interface arb_win_if
  import arb_pkg::*;
();

  // the winner is valid
  logic     req;
  // the winner is taken, may depend on req
  logic     gnt;
  // payload of the winner, valid while req is high
  payload_t data;
  // source index of the winner, valid while req is high
  idx_t     idx;

  // arbitration side
  modport arb (
    output req,
    output data,
    output idx,
    input  gnt
  );

  // consumer side
  modport sink (
    input  req,
    input  data,
    input  idx,
    output gnt
  );

endinterface : arb_win_if

`default_nettype wire

// File: lzc.sv
////////////////////////////////////////
// trailing zero counter
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module lzc import arb_pkg::*; #(
  parameter int unsigned Width = 2
) (
  input  logic [Width-1:0] in_i,
  output idx_t             cnt_o,
  output logic             empty_o
);

  // the input is padded up to a full binary tree
  localparam int unsigned NumLevels = $clog2(Width);
  localparam int unsigned NumLeaves = 2**NumLevels;
  localparam int unsigned NumNodes  = NumLeaves - 1;

  logic [NumLeaves-1:0] in_pad;
  idx_t [NumNodes-1:0]  idx_nodes;
  logic [NumNodes-1:0]  vld_nodes;

  // padding bits are zero so they never win
  assign in_pad = NumLeaves'(in_i);

  // node 0 is the root, node n has children 2n+1 and 2n+2
  for (genvar level = 0; level < NumLevels; level++) begin : gen_levels
    for (genvar l = 0; l < 2**level; l++) begin : gen_nodes
      localparam int unsigned Node = 2**level - 1 + l;
      logic sel;

      if (level == NumLevels - 1) begin : gen_leaf
        // take the upper bit only when the lower one is clear
        assign sel             = ~in_pad[2*l];
        assign vld_nodes[Node] = in_pad[2*l] | in_pad[2*l+1];
        assign idx_nodes[Node] = idx_t'(sel);
      end else begin : gen_inner
        localparam int unsigned Left = 2**(level+1) - 1 + 2*l;
        // the lower half wins whenever it holds any set bit
        assign sel             = ~vld_nodes[Left];
        assign vld_nodes[Node] = vld_nodes[Left] | vld_nodes[Left+1];
        assign idx_nodes[Node] = sel ?
          idx_t'({1'b1, idx_nodes[Left+1][NumLevels-level-2:0]}) :
          idx_t'({1'b0, idx_nodes[Left][NumLevels-level-2:0]});
      end
    end
  end

  // an all-zero input reports a count of zero
  assign empty_o = ~vld_nodes[0];
  assign cnt_o   = empty_o ? '0 : idx_nodes[0];

endmodule : lzc

`default_nettype wire

// File: rr_arb_tree.sv
////////////////////////////////////////
// round-robin arbitration tree
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module rr_arb_tree import arb_pkg::*; #(
  parameter int unsigned NumIn     = NumInDefault,
  parameter int unsigned DataWidth = DataWidthDefault,
  parameter bit          FairArb   = 1'b1,
  parameter bit          LockIn    = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic     [NumIn-1:0] req_i,
  input  payload_t [NumIn-1:0] data_i,
  output logic     [NumIn-1:0] gnt_o,
  arb_win_if.arb               win
);

  localparam int unsigned NumLevels = $clog2(NumIn);
  localparam int unsigned NumNodes  = 2**NumLevels - 1;

  // per-node request, grant, index and payload, node 0 is the root
  logic [NumNodes-1:0]                req_nodes;
  logic [NumNodes-1:0]                gnt_nodes;
  idx_t [NumNodes-1:0]                idx_nodes;
  logic [NumNodes-1:0][DataWidth-1:0] data_nodes;

  // requests as seen by the tree, frozen while a decision is locked
  logic [NumIn-1:0] req_d;
  // rr_q holds the input with the highest priority
  idx_t             rr_q;
  idx_t             rr_d;
  logic             xfer;

  // the root of the tree carries the final decision
  assign win.req      = req_nodes[0];
  assign win.data     = data_nodes[0];
  assign win.idx      = idx_nodes[0];
  assign gnt_nodes[0] = win.gnt;

  assign xfer = win.req & win.gnt;

  ////////////////////////////////////////
  // decision lock

  if (LockIn) begin : gen_lock
    logic             lock_q;
    logic [NumIn-1:0] req_q;

    // while locked the tree keeps seeing last cycle's requests
    assign req_d = lock_q ? req_q : req_i;

    // a pending winner that was not taken locks the decision
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_lock
      if (!rst_ni) begin
        lock_q <= 1'b0;
        req_q  <= '0;
      end else if (flush_i) begin
        lock_q <= 1'b0;
        req_q  <= '0;
      end else begin
        lock_q <= win.req & ~win.gnt;
        req_q  <= req_d;
      end
    end
  end else begin : gen_no_lock
    assign req_d = req_i;
  end

  ////////////////////////////////////////
  // next priority

  if (FairArb) begin : gen_fair
    logic [NumIn-1:0] upper_mask;
    logic [NumIn-1:0] lower_mask;
    idx_t             upper_idx;
    idx_t             lower_idx;
    logic             upper_empty;

    // split the requests around the index that is being served
    for (genvar i = 0; i < NumIn; i++) begin : gen_mask
      assign upper_mask[i] = (idx_t'(i) >  win.idx) ? req_d[i] : 1'b0;
      assign lower_mask[i] = (idx_t'(i) <= win.idx) ? req_d[i] : 1'b0;
    end

    lzc #(
      .Width   ( NumIn       )
    ) i_lzc_upper (
      .in_i    ( upper_mask  ),
      .cnt_o   ( upper_idx   ),
      .empty_o ( upper_empty )
    );

    // the served input itself sits in the lower half, so it is never empty on a transfer
    lzc #(
      .Width   ( NumIn       )
    ) i_lzc_lower (
      .in_i    ( lower_mask  ),
      .cnt_o   ( lower_idx   ),
      .empty_o (             )
    );

    // next waiting requester above the winner, else wrap to the lowest one
    assign rr_d = xfer ? (upper_empty ? lower_idx : upper_idx) : rr_q;
  end else begin : gen_plain
    // step the priority by one, independent of who is requesting
    assign rr_d = xfer ? ((rr_q == idx_t'(NumIn-1)) ? '0 : rr_q + 1'b1) : rr_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (flush_i) begin
      rr_q <= '0;
    end else begin
      rr_q <= rr_d;
    end
  end

  ////////////////////////////////////////
  // arbitration tree

  for (genvar level = 0; level < NumLevels; level++) begin : gen_levels
    for (genvar l = 0; l < 2**level; l++) begin : gen_nodes
      localparam int unsigned Node = 2**level - 1 + l;

      if (level == NumLevels - 1) begin : gen_leaf
        if (2*l < NumIn - 1) begin : gen_pair
          logic sel;
          // upper input wins when the lower one idles or the priority bit says so
          assign sel              = ~req_d[2*l] | (req_d[2*l+1] & rr_q[NumLevels-1-level]);
          assign req_nodes[Node]  = req_d[2*l] | req_d[2*l+1];
          assign idx_nodes[Node]  = idx_t'(sel);
          assign data_nodes[Node] = sel ? data_i[2*l+1] : data_i[2*l];
          assign gnt_o[2*l]       = gnt_nodes[Node] & req_d[2*l] & ~sel;
          assign gnt_o[2*l+1]     = gnt_nodes[Node] & req_d[2*l+1] & sel;
        end else if (2*l == NumIn - 1) begin : gen_single
          // odd input count leaves one input without a partner
          assign req_nodes[Node]  = req_d[2*l];
          assign idx_nodes[Node]  = '0;
          assign data_nodes[Node] = data_i[2*l];
          assign gnt_o[2*l]       = gnt_nodes[Node] & req_d[2*l];
        end else begin : gen_pruned
          // leaf beyond the last input never requests
          assign req_nodes[Node]  = 1'b0;
          assign idx_nodes[Node]  = '0;
          assign data_nodes[Node] = '0;
        end
      end else begin : gen_inner
        localparam int unsigned Left = 2**(level+1) - 1 + 2*l;
        logic sel;

        assign sel              = ~req_nodes[Left] |
                                  (req_nodes[Left+1] & rr_q[NumLevels-1-level]);
        assign req_nodes[Node]  = req_nodes[Left] | req_nodes[Left+1];
        // the index grows by one bit per level on the way to the root
        assign idx_nodes[Node]  = sel ?
          idx_t'({1'b1, idx_nodes[Left+1][NumLevels-level-2:0]}) :
          idx_t'({1'b0, idx_nodes[Left][NumLevels-level-2:0]});
        assign data_nodes[Node] = sel ? data_nodes[Left+1] : data_nodes[Left];
        // the grant follows the selected path back down
        assign gnt_nodes[Left]   = gnt_nodes[Node] & ~sel;
        assign gnt_nodes[Left+1] = gnt_nodes[Node] & sel;
      end
    end
  end

endmodule : rr_arb_tree

`default_nettype wire

// File: arb_out_stage.sv
////////////////////////////////////////
// arbiter output register
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module arb_out_stage import arb_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  arb_win_if.sink  win,
  output logic     req_o,
  output payload_t data_o,
  output idx_t     idx_o,
  input  logic     gnt_i
);

  // one held item with its source index
  logic     valid_q;
  payload_t data_q;
  idx_t     idx_q;
  logic     load;

  // accept when empty or when the held item leaves in this cycle
  assign win.gnt = ~valid_q | gnt_i;

  // a new item is taken on every transfer from the arbiter
  assign load = win.req & win.gnt;

  ////////////////////////////////////////
  // valid flag

  // while accepting, the next state is simply whether the arbiter offers an item
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (win.gnt) begin
      valid_q <= win.req;
    end
  end

  ////////////////////////////////////////
  // payload and index

  // held unchanged under back-pressure
  always_ff @(posedge clk_i) begin : p_payload
    if (load) begin
      data_q <= win.data;
      idx_q  <= win.idx;
    end
  end

  assign req_o  = valid_q;
  assign data_o = data_q;
  assign idx_o  = idx_q;

endmodule : arb_out_stage

`default_nettype wire

// File: arb_top.sv
////////////////////////////////////////
// request arbiter top
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module arb_top import arb_pkg::*; #(
  parameter int unsigned NumIn     = NumInDefault,
  parameter int unsigned DataWidth = DataWidthDefault,
  parameter bit          FairArb   = 1'b1,
  parameter bit          LockIn    = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // upstream requesters
  input  logic     [NumIn-1:0] req_i,
  input  payload_t [NumIn-1:0] data_i,
  output logic     [NumIn-1:0] gnt_o,
  // downstream consumer
  output logic                 req_o,
  output payload_t             data_o,
  output idx_t                 idx_o,
  input  logic                 gnt_i
);

  // winner channel between the tree and the output register
  arb_win_if win ();

  rr_arb_tree #(
    .NumIn     ( NumIn     ),
    .DataWidth ( DataWidth ),
    .FairArb   ( FairArb   ),
    .LockIn    ( LockIn    )
  ) i_arb (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .flush_i ( flush_i ),
    .req_i   ( req_i   ),
    .data_i  ( data_i  ),
    .gnt_o   ( gnt_o   ),
    .win     ( win     )
  );

  // flush leaves the held item in place
  arb_out_stage i_out (
    .clk_i  ( clk_i  ),
    .rst_ni ( rst_ni ),
    .win    ( win    ),
    .req_o  ( req_o  ),
    .data_o ( data_o ),
    .idx_o  ( idx_o  ),
    .gnt_i  ( gnt_i  )
  );

  // the package types are sized for the defaults, so the parameters must fit them
  initial begin : p_param_check
    assert (NumIn >= 2 && $clog2(NumIn) <= IdxWidthDefault)
      else $fatal(1, "NumIn does not fit the index type");
    assert (DataWidth == DataWidthDefault)
      else $fatal(1, "DataWidth does not match the payload type");
  end

endmodule : arb_top

`default_nettype wire

// File: arb_top_properties.sv
////////////////////////////////////////
// arbiter checks
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module arb_top_properties import arb_pkg::*; #(
  parameter int unsigned NumIn = NumInDefault
) (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 flush_i,
  input logic     [NumIn-1:0] req_i,
  input payload_t [NumIn-1:0] data_i,
  input logic     [NumIn-1:0] arb_gnt_i,
  input logic                 out_req_i,
  input payload_t             out_data_i,
  input idx_t                 out_idx_i,
  input logic                 out_gnt_i,
  // winner channel inside the top level
  input logic                 win_req_i,
  input idx_t                 win_idx_i
);

  // low payload bits hold the per-source sequence count
  localparam int unsigned SeqWidth = DataWidthDefault - IdxWidthDefault;

  logic accept;
  logic departs;
  idx_t gnt_idx;

  // what happened in the previous cycle
  logic                           last_gnt_q;
  idx_t                           last_idx_q;
  payload_t                       last_data_q;
  logic [NumIn-1:0]               last_req_q;
  logic                           last_flush_q;
  logic                           last_allreq_q;
  // a stalled winner in the previous cycle, and the one before it
  logic                           locked_q;
  logic                           locked_prev_q;
  idx_t                           pend_idx_q;
  // next expected sequence count per source
  logic [NumIn-1:0][SeqWidth-1:0] seq_q;
  logic                           failed = 1'b0;

  // the fair rule picks the lowest requester above the served one and wraps to the lowest one
  function automatic idx_t next_in_turn(logic [NumIn-1:0] req, idx_t served);
    idx_t lowest;
    idx_t above;
    logic has_above;
    lowest    = '0;
    above     = '0;
    has_above = 1'b0;
    for (int i = NumIn - 1; i >= 0; i--) begin
      if (req[i]) begin
        lowest = idx_t'(i);
      end
      if (req[i] && i > int'(served)) begin
        above     = idx_t'(i);
        has_above = 1'b1;
      end
    end
    return has_above ? above : lowest;
  endfunction

  // the output register takes a new item when empty or draining
  assign accept  = ~out_req_i | out_gnt_i;
  assign departs = out_req_i & out_gnt_i;

  always_comb begin : p_gnt_idx
    gnt_idx = '0;
    for (int i = 0; i < NumIn; i++) begin
      if (arb_gnt_i[i]) begin
        gnt_idx = idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_history
    if (!rst_ni) begin
      last_gnt_q    <= 1'b0;
      last_idx_q    <= '0;
      last_data_q   <= '0;
      last_req_q    <= '0;
      last_flush_q  <= 1'b0;
      last_allreq_q <= 1'b0;
      locked_q      <= 1'b0;
      locked_prev_q <= 1'b0;
      pend_idx_q    <= '0;
      seq_q         <= '0;
    end else begin
      last_gnt_q    <= |arb_gnt_i;
      last_idx_q    <= gnt_idx;
      last_data_q   <= data_i[gnt_idx];
      last_req_q    <= req_i;
      last_flush_q  <= flush_i;
      last_allreq_q <= &req_i;
      locked_q      <= win_req_i & ~accept & ~flush_i;
      locked_prev_q <= locked_q;
      pend_idx_q    <= win_idx_i;
      if (departs) begin
        seq_q[out_idx_i] <= seq_q[out_idx_i] + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // grant sanity

  a_gnt_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(arb_gnt_i) && ((arb_gnt_i & ~req_i) == '0))
  else begin
    $error("grant is not one-hot or goes to an idle input: gnt %b req %b",
           $sampled(arb_gnt_i), $sampled(req_i));
    failed = 1'b1;
  end

  a_gnt_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|req_i && accept) |-> |arb_gnt_i)
  else begin
    $error("requests are pending and the output can accept, but nothing is granted");
    failed = 1'b1;
  end

  ////////////////////////////////////////
  // output timing and contents

  a_latency : assert property (@(posedge clk_i) disable iff (!rst_ni)
    last_gnt_q |-> (out_req_i && out_idx_i == last_idx_q && out_data_i == last_data_q))
  else begin
    $error("[ERROR] %0t latency: expected idx %0d data %h, observed req %b idx %0d data %h",
           $time, $sampled(last_idx_q), $sampled(last_data_q), $sampled(out_req_i),
           $sampled(out_idx_i), $sampled(out_data_i));
    failed = 1'b1;
  end

  a_src_bits : assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_req_i |-> (out_data_i[DataWidthDefault-1 -: IdxWidthDefault] == out_idx_i))
  else begin
    $error("[ERROR] %0t source bits: expected %0d, observed %0d", $time, $sampled(out_idx_i),
           $sampled(out_data_i[DataWidthDefault-1 -: IdxWidthDefault]));
    failed = 1'b1;
  end

  // a stalled output holds its item
  a_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_req_i && !out_gnt_i) |=> (out_req_i && $stable(out_data_i) && $stable(out_idx_i)))
  else begin
    $error("[ERROR] %0t hold: expected item %h idx %0d, observed req %b item %h idx %0d",
           $time, $past(out_data_i), $past(out_idx_i), $sampled(out_req_i),
           $sampled(out_data_i), $sampled(out_idx_i));
    failed = 1'b1;
  end

  ////////////////////////////////////////
  // arbitration order

  a_rotation : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (last_gnt_q && |arb_gnt_i && req_i == last_req_q && !last_flush_q && !locked_prev_q)
      |-> (gnt_idx == next_in_turn(last_req_q, last_idx_q)))
  else begin
    $error("[ERROR] %0t rotation after %0d: expected grant %0d, observed %0d", $time,
           $sampled(last_idx_q), next_in_turn($sampled(last_req_q), $sampled(last_idx_q)),
           $sampled(gnt_idx));
    failed = 1'b1;
  end

  // the decision pending at a stall stays, and its grant comes first
  a_lock : assert property (@(posedge clk_i) disable iff (!rst_ni)
    locked_q |-> (win_req_i && win_idx_i == pend_idx_q &&
                  (arb_gnt_i == '0 || gnt_idx == pend_idx_q)))
  else begin
    $error("[ERROR] %0t lock: expected idx %0d, observed winner %0d grant %b", $time,
           $sampled(pend_idx_q), $sampled(win_idx_i), $sampled(arb_gnt_i));
    failed = 1'b1;
  end

  a_order : assert property (@(posedge clk_i) disable iff (!rst_ni)
    departs |-> (out_data_i[SeqWidth-1:0] == seq_q[out_idx_i]))
  else begin
    $error("[ERROR] %0t order of source %0d: expected count %0d, observed %0d", $time,
           $sampled(out_idx_i), $sampled(seq_q[out_idx_i]),
           $sampled(out_data_i[SeqWidth-1:0]));
    failed = 1'b1;
  end

  // priority restarts at input 0 after a flush
  a_flush : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (last_flush_q && last_allreq_q && req_i[0] && accept) |-> arb_gnt_i[0])
  else begin
    $error("[ERROR] %0t flush: expected grant %b, observed %b", $time,
           NumIn'(1), $sampled(arb_gnt_i));
    failed = 1'b1;
  end

endmodule : arb_top_properties

bind arb_top arb_top_properties #(
  .NumIn      ( NumIn   )
) i_props (
  .clk_i      ( clk_i   ),
  .rst_ni     ( rst_ni  ),
  .flush_i    ( flush_i ),
  .req_i      ( req_i   ),
  .data_i     ( data_i  ),
  .arb_gnt_i  ( gnt_o   ),
  .out_req_i  ( req_o   ),
  .out_data_i ( data_o  ),
  .out_idx_i  ( idx_o   ),
  .out_gnt_i  ( gnt_i   ),
  .win_req_i  ( win.req ),
  .win_idx_i  ( win.idx )
);

`default_nettype wire

// File: tb_arb_top.sv
////////////////////////////////////////
// arbiter testbench
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_arb_top import arb_pkg::*; ();

  localparam int unsigned NumItems   = 2000;
  // about 0.7 items per cycle leave under random back-pressure, so the limit has ample margin
  localparam int unsigned MaxCycles  = 6000;
  // full-throughput window
  localparam int unsigned BurstStart = 400;
  localparam int unsigned BurstEnd   = 500;
  // all requests high around the flush pulse
  localparam int unsigned FlushStart = 800;
  localparam int unsigned FlushCycle = 810;
  localparam int unsigned FlushEnd   = 820;
  localparam int unsigned SeqWidth   = DataWidthDefault - IdxWidthDefault;

  logic                        clk_i;
  logic                        rst_ni  = 1'b0;
  logic                        flush_i = 1'b0;
  logic     [NumInDefault-1:0] req_i   = '0;
  payload_t [NumInDefault-1:0] data_i  = '0;
  logic     [NumInDefault-1:0] gnt_o;
  logic                        req_o;
  payload_t                    data_o;
  idx_t                        idx_o;
  logic                        gnt_i   = 1'b0;

  // sequence count of the item each requester presents
  logic [SeqWidth-1:0] seq_cnt [NumInDefault] = '{default: '0};
  int unsigned         cycles     = 0;
  int unsigned         departures = 0;

  arb_top i_dut (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .flush_i ( flush_i ),
    .req_i   ( req_i   ),
    .data_i  ( data_i  ),
    .gnt_o   ( gnt_o   ),
    .req_o   ( req_o   ),
    .data_o  ( data_o  ),
    .idx_o   ( idx_o   ),
    .gnt_i   ( gnt_i   )
  );

  initial begin : p_clock
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // stimulus

  // each requester holds its item until granted, then offers the next count
  initial begin : p_stimulus
    logic all_high;
    void'($urandom(32'h8859_1320));
    forever begin
      @(posedge clk_i);
      if (rst_ni) begin
        all_high = (cycles >= BurstStart && cycles < BurstEnd) ||
                   (cycles >= FlushStart && cycles < FlushEnd);
        cycles <= cycles + 1;
        if (req_o && gnt_i) begin
          departures <= departures + 1;
        end
        gnt_i   <= all_high || ($urandom_range(99) < 70);
        flush_i <= (cycles == FlushCycle);
        for (int i = 0; i < NumInDefault; i++) begin
          if (gnt_o[i]) begin
            seq_cnt[i] = seq_cnt[i] + 1'b1;
          end
          if (gnt_o[i] || !req_i[i]) begin
            req_i[i]  <= all_high || ($urandom_range(9) < 6);
            data_i[i] <= {idx_t'(i), seq_cnt[i]};
          end
        end
      end
    end
  end

  // stop at the first failed assertion
  always @(negedge clk_i) begin : p_fail_watch
    if (i_dut.i_props.failed) begin
      $display("=== FAIL ===");
      $fatal(1, "assertion failed at %0t", $time);
    end
  end

  ////////////////////////////////////////
  // run control

  initial begin : p_main
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    while (departures < NumItems && cycles < MaxCycles) begin
      @(negedge clk_i);
    end
    if (departures < NumItems) begin
      $display("timeout: too few items left the arbiter");
      $display("=== FAIL ===");
      $fatal(1, "only %0d items after %0d cycles", departures, cycles);
    end else if (i_dut.i_props.failed) begin
      $display("=== FAIL ===");
      $fatal(1, "an assertion failed during the run");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule : tb_arb_top

`default_nettype wire

// File: sim.f
arb_pkg.sv
arb_win_if.sv
lzc.sv
rr_arb_tree.sv
arb_out_stage.sv
arb_top.sv
arb_top_properties.sv
tb_arb_top.sv

// File: Makefile
# Verilator build and run of the arbiter testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fails unless the run passes"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f sim.f --top-module tb_arb_top -o sim_tb
	@out=$$(./obj_dir/sim_tb +verilator+error+limit+10); \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir
